// File: src/rvPkg.sv
package rvPkg;

    typedef logic [31:0] word_t;    // Data or address word
    typedef logic [4:0]  regIdx_t;  // Register index
    typedef logic [3:0]  aluOp_t;   // ALU operation code
    typedef logic [1:0]  wbSel_t;   // Write-back source
    typedef logic [1:0]  sizeSel_t; // Access size

    // Major opcodes, instruction bits 6 to 2
    localparam logic [4:0] OpcOp      = 5'b01100;
    localparam logic [4:0] OpcOpImm   = 5'b00100;
    localparam logic [4:0] OpcLoad    = 5'b00000;
    localparam logic [4:0] OpcStore   = 5'b01000;
    localparam logic [4:0] OpcBranch  = 5'b11000;
    localparam logic [4:0] OpcJal     = 5'b11011;
    localparam logic [4:0] OpcJalr    = 5'b11001;
    localparam logic [4:0] OpcLui     = 5'b01101;
    localparam logic [4:0] OpcAuipc   = 5'b00101;
    localparam logic [4:0] OpcMiscMem = 5'b00011;
    localparam logic [4:0] OpcSystem  = 5'b11100;

    localparam aluOp_t AluAdd  = 4'b0000;
    localparam aluOp_t AluSub  = 4'b0001;
    localparam aluOp_t AluAnd  = 4'b0010;
    localparam aluOp_t AluOr   = 4'b0011;
    localparam aluOp_t AluXor  = 4'b0100;
    localparam aluOp_t AluSll  = 4'b0101;
    localparam aluOp_t AluSrl  = 4'b0110;
    localparam aluOp_t AluSra  = 4'b0111;
    localparam aluOp_t AluSlt  = 4'b1000;
    localparam aluOp_t AluSltu = 4'b1001;

    localparam wbSel_t WbAlu   = 2'd0; // ALU or load result
    localparam wbSel_t WbLui   = 2'd1;
    localparam wbSel_t WbAuipc = 2'd2;
    localparam wbSel_t WbPc4   = 2'd3; // Link value

    localparam sizeSel_t SizeByte = 2'd0;
    localparam sizeSel_t SizeHalf = 2'd1;
    localparam sizeSel_t SizeWord = 2'd2;

endpackage

// File: src/ctrlIf.sv
interface ctrlIf;

    import rvPkg::*;

    aluOp_t   aluCtrl;
    logic     aluImm;      // Operand B from immediate
    logic     aluToPc;     // JALR target from ALU
    logic     branch;      // Taken branch or jump
    logic     memToReg;
    logic     memWr;
    wbSel_t   regDataSel;
    logic     regWr;
    sizeSel_t loadSel;
    sizeSel_t maskSel;
    logic     rs2ShiftSel; // Half-word lane replication
    logic     uext;        // Zero-extend loads

    modport dec (
        output aluCtrl, aluImm, aluToPc, branch,
        output memToReg, memWr, regDataSel, regWr,
        output loadSel, maskSel, rs2ShiftSel, uext
    );

    modport dp (
        input aluCtrl, aluImm, aluToPc, branch,
        input memToReg, memWr, regDataSel, regWr,
        input loadSel, maskSel, rs2ShiftSel, uext
    );

endinterface

// File: src/immDecoder.sv
module immDecoder (
    input  rvPkg::word_t instruction,
    output rvPkg::word_t imm
);

    import rvPkg::*;

    logic [4:0] opcode;
    word_t      instr;

    assign opcode = instruction[6:2];
    assign instr  = instruction;

    always_comb begin
        case (opcode)
            OpcLoad, OpcOpImm, OpcJalr:
                imm = {{20{instr[31]}}, instr[31:20]}; // I-type
            OpcStore:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]}; // S-type
            OpcBranch:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0}; // B-type
            OpcLui, OpcAuipc:
                imm = {instr[31:12], 12'b0}; // Upper 20 bits
            OpcJal:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0}; // J-type
            default:
                imm = '0;
        endcase
    end

endmodule

// File: src/controller.sv
module controller (
    input  rvPkg::word_t instruction,
    input  logic         aluZero,
    ctrlIf.dec           ctl
);

    import rvPkg::*;

    logic [2:0] funct3;
    logic       funct7b5;
    logic [4:0] opcode;

    assign funct3   = instruction[14:12];
    assign funct7b5 = instruction[30];
    assign opcode   = instruction[6:2]; // Low two bits always 11

    // Size and extension come straight from funct3
    always_comb begin
        ctl.loadSel     = funct3[1:0];
        ctl.maskSel     = funct3[1:0];
        ctl.rs2ShiftSel = funct3[0];
        ctl.uext        = funct3[2];
    end

    always_comb begin
        ctl.aluCtrl    = AluAdd;
        ctl.aluImm     = 1'b0;
        ctl.aluToPc    = 1'b0;
        ctl.branch     = 1'b0;
        ctl.memToReg   = 1'b0;
        ctl.memWr      = 1'b0;
        ctl.regDataSel = WbAlu;
        ctl.regWr      = 1'b0;

        case (opcode)
            OpcOp: begin
                ctl.regWr = 1'b1;
                case (funct3)
                    3'b000:  ctl.aluCtrl = funct7b5 ? AluSub : AluAdd;
                    3'b001:  ctl.aluCtrl = AluSll;
                    3'b010:  ctl.aluCtrl = AluSlt;
                    3'b011:  ctl.aluCtrl = AluSltu;
                    3'b100:  ctl.aluCtrl = AluXor;
                    3'b101:  ctl.aluCtrl = funct7b5 ? AluSra : AluSrl;
                    3'b110:  ctl.aluCtrl = AluOr;
                    default: ctl.aluCtrl = AluAnd;
                endcase
            end

            OpcOpImm: begin
                ctl.aluImm = 1'b1;
                ctl.regWr  = 1'b1;
                case (funct3)
                    3'b000:  ctl.aluCtrl = AluAdd; // No SUBI
                    3'b001:  ctl.aluCtrl = AluSll;
                    3'b010:  ctl.aluCtrl = AluSlt;
                    3'b011:  ctl.aluCtrl = AluSltu;
                    3'b100:  ctl.aluCtrl = AluXor;
                    3'b101:  ctl.aluCtrl = funct7b5 ? AluSra : AluSrl;
                    3'b110:  ctl.aluCtrl = AluOr;
                    default: ctl.aluCtrl = AluAnd;
                endcase
            end

            OpcLoad: begin
                ctl.aluImm   = 1'b1; // Address is rs1 plus offset
                ctl.memToReg = 1'b1;
                ctl.regWr    = 1'b1;
            end

            OpcStore: begin
                ctl.aluImm = 1'b1;
                ctl.memWr  = 1'b1;
            end

            OpcBranch: begin
                case (funct3)
                    3'b000: begin // BEQ
                        ctl.aluCtrl = AluSub;
                        ctl.branch  = aluZero;
                    end
                    3'b001: begin // BNE
                        ctl.aluCtrl = AluSub;
                        ctl.branch  = ~aluZero;
                    end
                    3'b100: begin // BLT
                        ctl.aluCtrl = AluSlt;
                        ctl.branch  = ~aluZero;
                    end
                    3'b101: begin // BGE
                        ctl.aluCtrl = AluSlt;
                        ctl.branch  = aluZero;
                    end
                    3'b110: begin // BLTU
                        ctl.aluCtrl = AluSltu;
                        ctl.branch  = ~aluZero;
                    end
                    3'b111: begin // BGEU
                        ctl.aluCtrl = AluSltu;
                        ctl.branch  = aluZero;
                    end
                    default: ctl.branch = 1'b0; // Reserved encodings fall through
                endcase
            end

            OpcJal: begin
                ctl.branch     = 1'b1;
                ctl.regDataSel = WbPc4;
                ctl.regWr      = 1'b1;
            end

            OpcJalr: begin
                ctl.aluImm     = 1'b1;
                ctl.aluToPc    = 1'b1;
                ctl.branch     = 1'b1;
                ctl.regDataSel = WbPc4;
                ctl.regWr      = 1'b1;
            end

            OpcLui: begin
                ctl.regDataSel = WbLui;
                ctl.regWr      = 1'b1;
            end

            OpcAuipc: begin
                ctl.regDataSel = WbAuipc;
                ctl.regWr      = 1'b1;
            end

            OpcMiscMem, OpcSystem: begin
                // FENCE, CSR and environment calls retire as no-ops
            end

            default: begin
            end
        endcase
    end

endmodule

// File: src/regFile.sv
module regFile #(
    parameter int RegCount = 32
) (
    input  logic          clk,
    input  logic          rstN,
    input  rvPkg::regIdx_t rs1Addr,
    input  rvPkg::regIdx_t rs2Addr,
    input  rvPkg::regIdx_t rdAddr,
    input  rvPkg::word_t   rdData,
    input  logic          regWr,
    output rvPkg::word_t   rs1Data,
    output rvPkg::word_t   rs2Data
);

    import rvPkg::*;

    word_t regs [RegCount];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (regWr && (rdAddr != '0)) begin // x0 stays zero
            regs[rdAddr] <= rdData;
        end
    end

    // Combinational read ports
    assign rs1Data = regs[rs1Addr];
    assign rs2Data = regs[rs2Addr];

endmodule

// File: src/alu.sv
module alu (
    ctrlIf.dp            ctl,
    input  rvPkg::word_t a,
    input  rvPkg::word_t b,
    output rvPkg::word_t result,
    output logic         zero
);

    import rvPkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0]; // Only low 5 bits shift

    always_comb begin
        case (ctl.aluCtrl)
            AluAdd:  result = a + b;
            AluSub:  result = a - b;
            AluAnd:  result = a & b;
            AluOr:   result = a | b;
            AluXor:  result = a ^ b;
            AluSll:  result = a << shamt;
            AluSrl:  result = a >> shamt;
            AluSra:  result = word_t'($signed(a) >>> shamt);
            AluSlt:  result = {31'b0, $signed(a) < $signed(b)};
            AluSltu: result = {31'b0, a < b};
            default: result = '0;
        endcase
    end

    assign zero = (result == '0); // Feeds branch resolution

endmodule

// File: src/loadStore.sv
module loadStore (
    ctrlIf.dp            ctl,
    input  rvPkg::word_t addr,
    input  rvPkg::word_t storeData,
    input  rvPkg::word_t readData,
    output rvPkg::word_t writeData,
    output rvPkg::word_t loadData,
    output logic [3:0]   byteEn
);

    import rvPkg::*;

    logic [1:0] offset;
    word_t      shifted;

    assign offset = addr[1:0];

    // Replicate rs2 so every lane holds the right bytes
    always_comb begin
        if (ctl.maskSel == SizeByte) begin
            writeData = {4{storeData[7:0]}};
        end else if (ctl.rs2ShiftSel) begin
            writeData = {2{storeData[15:0]}};
        end else begin
            writeData = storeData;
        end
    end

    always_comb begin
        byteEn = 4'b0000;
        if (ctl.memWr) begin
            case (ctl.maskSel)
                SizeByte: byteEn = 4'b0001 << offset;
                SizeHalf: byteEn = offset[1] ? 4'b1100 : 4'b0011;
                default:  byteEn = 4'b1111;
            endcase
        end
    end

    assign shifted = readData >> {offset, 3'b000}; // Move addressed byte to lane 0

    always_comb begin
        case (ctl.loadSel)
            SizeByte: loadData = ctl.uext ? {24'b0, shifted[7:0]}
                                          : {{24{shifted[7]}}, shifted[7:0]};
            SizeHalf: loadData = ctl.uext ? {16'b0, shifted[15:0]}
                                          : {{16{shifted[15]}}, shifted[15:0]};
            default:  loadData = shifted;
        endcase
    end

endmodule

// File: src/rvCore.sv
module rvCore #(
    parameter rvPkg::word_t ResetPc  = '0,
    parameter int           RegCount = 32
) (
    input  logic         clk,
    input  logic         rstN,
    input  rvPkg::word_t instruction,
    input  rvPkg::word_t readData,
    output rvPkg::word_t instrAddr,
    output rvPkg::word_t dataAddr,
    output rvPkg::word_t writeData,
    output logic [3:0]   byteEn,
    output logic         dataWr
);

    import rvPkg::*;

    word_t   pc;
    word_t   pcNext;
    word_t   pcPlus4;
    word_t   pcImm;
    word_t   imm;
    word_t   rs1Data;
    word_t   rs2Data;
    word_t   aluB;
    word_t   aluResult;
    word_t   loadData;
    word_t   rdData;
    logic    aluZero;
    regIdx_t rs1Addr;
    regIdx_t rs2Addr;
    regIdx_t rdAddr;

    ctrlIf ctl ();

    assign rs1Addr = instruction[19:15];
    assign rs2Addr = instruction[24:20];
    assign rdAddr  = instruction[11:7];

    controller uController (
        .instruction (instruction),
        .aluZero     (aluZero),
        .ctl         (ctl.dec)
    );

    immDecoder uImmDecoder (
        .instruction (instruction),
        .imm         (imm)
    );

    regFile #(
        .RegCount (RegCount)
    ) uRegFile (
        .clk     (clk),
        .rstN    (rstN),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rdAddr  (rdAddr),
        .rdData  (rdData),
        .regWr   (ctl.regWr),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    assign aluB = ctl.aluImm ? imm : rs2Data;

    alu uAlu (
        .ctl    (ctl.dp),
        .a      (rs1Data),
        .b      (aluB),
        .result (aluResult),
        .zero   (aluZero)
    );

    loadStore uLoadStore (
        .ctl       (ctl.dp),
        .addr      (aluResult),
        .storeData (rs2Data),
        .readData  (readData),
        .writeData (writeData),
        .loadData  (loadData),
        .byteEn    (byteEn)
    );

    assign dataAddr = aluResult;
    assign dataWr   = ctl.memWr;

    assign pcPlus4 = pc + 32'd4;
    assign pcImm   = pc + imm; // Branch, JAL and AUIPC

    always_comb begin
        case (ctl.regDataSel)
            WbLui:   rdData = imm;
            WbAuipc: rdData = pcImm;
            WbPc4:   rdData = pcPlus4; // Link address
            default: rdData = ctl.memToReg ? loadData : aluResult;
        endcase
    end

    always_comb begin
        if (!ctl.branch) begin
            pcNext = pcPlus4;
        end else if (ctl.aluToPc) begin
            pcNext = {aluResult[31:1], 1'b0}; // JALR clears bit 0
        end else begin
            pcNext = pcImm;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= ResetPc;
        end else begin
            pc <= pcNext;
        end
    end

    assign instrAddr = pc;

endmodule

// File: verif/tbRvCore.sv
module tbRvCore;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          ClkPeriod   = 100;
    localparam int          ResetCycles = 8;
    localparam int          MaxRows     = 512;
    localparam logic [31:0] StoreBase   = 32'h100; // Scratch words for result stores
    localparam logic [31:0] LoadBase    = 32'h200; // Preloaded words, never written

    localparam logic [6:0] OpcodeLui    = 7'b0110111;
    localparam logic [6:0] OpcodeAuipc  = 7'b0010111;
    localparam logic [6:0] OpcodeJal    = 7'b1101111;
    localparam logic [6:0] OpcodeJalr   = 7'b1100111;
    localparam logic [6:0] OpcodeBranch = 7'b1100011;
    localparam logic [6:0] OpcodeLoad   = 7'b0000011;
    localparam logic [6:0] OpcodeStore  = 7'b0100011;
    localparam logic [6:0] OpcodeOpImm  = 7'b0010011;
    localparam logic [6:0] OpcodeOp     = 7'b0110011;

    localparam int KindNone  = 0;
    localparam int KindLoad  = 1;
    localparam int KindStore = 2;

    logic        clk;
    logic        rstN;
    logic [31:0] instruction;
    logic [31:0] readData;
    logic [31:0] instrAddr;
    logic [31:0] dataAddr;
    logic [31:0] writeData;
    logic [3:0]  byteEn;
    logic        dataWr;

    logic [31:0] imem [1024];
    logic [31:0] dmem [256];

    // One row per retired instruction
    string       rowName [MaxRows];
    logic [31:0] rowPc   [MaxRows];
    logic [31:0] rowNext [MaxRows];
    int          rowKind [MaxRows];
    logic [31:0] rowAddr [MaxRows];
    logic [3:0]  rowBe   [MaxRows];
    logic [31:0] rowData [MaxRows];

    int          rowCount;
    logic [31:0] curPc;
    logic [31:0] xr [32]; // Architectural register values of the trace
    integer      seed;
    logic        built;

    rvCore #(
        .ResetPc  (32'h0),
        .RegCount (32)
    ) DUT (
        .clk         (clk),
        .rstN        (rstN),
        .instruction (instruction),
        .readData    (readData),
        .instrAddr   (instrAddr),
        .dataAddr    (dataAddr),
        .writeData   (writeData),
        .byteEn      (byteEn),
        .dataWr      (dataWr)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    assign instruction = imem[instrAddr[11:2]]; // Combinational fetch

    always @(posedge clk) begin
        if (dataWr) begin
            for (int i = 0; i < 4; i++) begin
                if (byteEn[i]) begin
                    dmem[dataAddr[9:2]][8*i +: 8] <= writeData[8*i +: 8];
                end
            end
        end
    end

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OpcodeOp};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opcode);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OpcodeStore};
    endfunction

    function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OpcodeBranch};
    endfunction

    function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opcode);
        return {imm, rd, opcode};
    endfunction

    function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OpcodeJal};
    endfunction

    function automatic logic [31:0] dmemFill(input logic [7:0] idx);
        return {~idx, idx ^ 8'h3c, idx, idx ^ 8'hc3}; // Mixed sign bits per lane
    endfunction

    // RV32I integer semantics by funct3 and the alternate bit
    function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = {31'b0, $signed(a) < $signed(b)};
            3'd3: r = {31'b0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branchModel(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] loadModel(input logic [2:0] f3, input logic [31:0] w,
                                              input int off);
        logic [7:0]  b8;
        logic [15:0] h16;
        b8  = w[8*off +: 8];
        h16 = w[16*(off / 2) +: 16];
        case (f3)
            3'd0: return {{24{b8[7]}}, b8};
            3'd1: return {{16{h16[15]}}, h16};
            3'd4: return {24'b0, b8};
            3'd5: return {16'b0, h16};
            default: return w;
        endcase
    endfunction

    // Index to {alt, funct3} over the ten OP encodings
    function automatic logic [3:0] opCode(input int i);
        case (i)
            0: return 4'b0000;
            1: return 4'b1000;
            2: return 4'b0001;
            3: return 4'b0010;
            4: return 4'b0011;
            5: return 4'b0100;
            6: return 4'b0101;
            7: return 4'b1101;
            8: return 4'b0110;
            default: return 4'b0111;
        endcase
    endfunction

    function automatic string opName(input int i);
        case (i)
            0: return "ADD";
            1: return "SUB";
            2: return "SLL";
            3: return "SLT";
            4: return "SLTU";
            5: return "XOR";
            6: return "SRL";
            7: return "SRA";
            8: return "OR";
            default: return "AND";
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic addRow(input string name, input logic [31:0] instr,
                          input logic [31:0] nextPc, input int kind, input logic [31:0] addr,
                          input logic [3:0] be, input logic [31:0] data);
        rowName[rowCount] = name;
        rowPc[rowCount]   = curPc;
        rowNext[rowCount] = nextPc;
        rowKind[rowCount] = kind;
        rowAddr[rowCount] = addr;
        rowBe[rowCount]   = be;
        rowData[rowCount] = data;
        imem[curPc[11:2]] = instr;
        curPc             = nextPc;
        rowCount++;
    endtask

    task automatic plainRow(input string name, input logic [31:0] instr);
        addRow(name, instr, curPc + 32'd4, KindNone, '0, '0, '0);
    endtask

    task automatic writeReg(input logic [4:0] rd, input logic [31:0] value);
        if (rd != 5'd0) begin
            xr[rd] = value; // x0 is hardwired to zero
        end
    endtask

    task automatic setReg(input logic [4:0] rd, input logic [31:0] value);
        logic [19:0] upper;
        upper = value[31:12] + {19'b0, value[11]}; // Compensate sign of low part
        plainRow("LUI setup", uType(upper, rd, OpcodeLui));
        plainRow("ADDI setup", iType(value[11:0], rd, 3'd0, rd, OpcodeOpImm));
        writeReg(rd, value);
    endtask

    task automatic storeCheck(input string name, input logic [2:0] f3, input logic [4:0] rs2,
                              input int off);
        logic [31:0] addr;
        logic [31:0] v;
        logic [3:0]  be;
        logic [31:0] data;
        int          bytes;
        addr  = StoreBase + off;
        v     = xr[rs2];
        bytes = 1 << f3[1:0]; // Access size in bytes
        for (int i = 0; i < 4; i++) begin
            be[i]          = (i >= off) && (i < off + bytes); // Lanes covered by the access
            data[8*i +: 8] = v[8*(i % bytes) +: 8];
        end
        addRow(name, sType(addr[11:0], rs2, 5'd0, f3), curPc + 32'd4, KindStore, addr, be, data);
    endtask

    task automatic resultRow(input string name, input logic [31:0] instr, input logic [4:0] rd,
                             input logic [31:0] value);
        plainRow(name, instr);
        writeReg(rd, value);
        storeCheck({name, " SW"}, 3'd2, rd, 0);
    endtask

    task automatic aluGroup();
        logic [3:0]  code;
        logic [11:0] imm;
        setReg(5'd1, $random(seed) | 32'h8000_0000); // Negative so signed and unsigned differ
        setReg(5'd2, ($random(seed) & 32'h7fff_ffff) | 32'h1); // Odd shift amount
        for (int i = 0; i < 10; i++) begin
            code = opCode(i);
            resultRow(opName(i), rType({1'b0, code[3], 5'b0}, 5'd2, 5'd1, code[2:0], 5'd3),
                      5'd3, aluModel(code[2:0], code[3], xr[1], xr[2]));
        end
        for (int i = 0; i < 10; i++) begin
            code = opCode(i);
            if (i != 1) begin // No SUB immediate form
                imm = $random(seed);
                if (code[1:0] == 2'b01) begin
                    imm = {1'b0, code[3], 5'b0, imm[4:1], 1'b1}; // Odd shift amount field
                end
                resultRow({opName(i), " imm"}, iType(imm, 5'd1, code[2:0], 5'd4, OpcodeOpImm),
                          5'd4, aluModel(code[2:0], code[3], xr[1], {{20{imm[11]}}, imm}));
            end
        end
    endtask

    task automatic storeGroup();
        setReg(5'd5, $random(seed));
        for (int off = 0; off < 4; off++) begin
            storeCheck($sformatf("SB offset %0d", off), 3'd0, 5'd5, off);
        end
        storeCheck("SH offset 0", 3'd1, 5'd5, 0);
        storeCheck("SH offset 2", 3'd1, 5'd5, 2);
        storeCheck("SW word", 3'd2, 5'd5, 0);
    endtask

    task automatic loadGroup();
        logic [31:0] word;
        logic [31:0] addr;
        logic [2:0]  f3;
        string       name;
        word = dmemFill(LoadBase[9:2]);
        for (int f = 0; f < 6; f++) begin
            f3 = f;
            if (f != 3) begin
                for (int off = 0; off < 4; off += (1 << f3[1:0])) begin
                    addr = LoadBase + off;
                    name = $sformatf("load funct3 %0d offset %0d", f, off);
                    addRow(name, iType(addr[11:0], 5'd0, f3, 5'd6, OpcodeLoad), curPc + 32'd4,
                           KindLoad, addr, '0, '0);
                    writeReg(5'd6, loadModel(f3, word, off));
                    storeCheck({name, " SW"}, 3'd2, 5'd6, 0);
                end
            end
        end
    endtask

    task automatic branchGroup();
        logic [2:0] f3;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic       taken;
        setReg(5'd1, $random(seed) | 32'h8000_0000); // Signed and unsigned order disagree
        setReg(5'd2, $random(seed) & 32'h7fff_ffff);
        setReg(5'd3, xr[1]); // Equal pair for BEQ and BGE
        for (int f = 0; f < 8; f++) begin
            f3 = f;
            if (f != 2 && f != 3) begin
                for (int p = 0; p < 3; p++) begin
                    rs1   = (p == 1) ? 5'd2 : 5'd1;
                    rs2   = (p == 0) ? 5'd2 : ((p == 1) ? 5'd1 : 5'd3);
                    taken = branchModel(f3, xr[rs1], xr[rs2]);
                    addRow($sformatf("branch funct3 %0d x%0d x%0d", f, rs1, rs2),
                           bType(13'd8, rs2, rs1, f3), taken ? curPc + 32'd8 : curPc + 32'd4,
                           KindNone, '0, '0, '0); // Taken skips one slot
                end
            end
        end
    endtask

    task automatic jumpGroup();
        logic [31:0] jalrPc;
        writeReg(5'd7, curPc + 32'd4);
        addRow("JAL", jType(21'd12, 5'd7), curPc + 32'd12, KindNone, '0, '0, '0);
        storeCheck("JAL link", 3'd2, 5'd7, 0);
        jalrPc = curPc + 32'd8; // After the two setup rows
        setReg(5'd8, jalrPc + 32'd16);
        writeReg(5'd9, jalrPc + 32'd4);
        addRow("JALR", iType(12'd1, 5'd8, 3'd0, 5'd9, OpcodeJalr),
               (xr[8] + 32'd1) & ~32'd1, KindNone, '0, '0, '0); // Odd sum gets bit 0 cleared
        storeCheck("JALR link", 3'd2, 5'd9, 0);
    endtask

    task automatic upperGroup();
        logic [19:0] upper;
        upper = $random(seed);
        resultRow("LUI", uType(upper, 5'd10, OpcodeLui), 5'd10, {upper, 12'b0});
        upper = $random(seed);
        resultRow("AUIPC", uType(upper, 5'd11, OpcodeAuipc), 5'd11, curPc + {upper, 12'b0});
        plainRow("LUI x0", uType(upper, 5'd0, OpcodeLui));
        resultRow("ADDI x0", iType(12'h7ff, 5'd0, 3'd0, 5'd0, OpcodeOpImm), 5'd0, 32'h7ff);
    endtask

    task automatic checkRow(input int k);
        checkValue({rowName[k], " instrAddr"}, rowPc[k], instrAddr);
        checkValue({rowName[k], " dataWr"}, {31'b0, rowKind[k] == KindStore}, {31'b0, dataWr});
        if (rowKind[k] == KindStore) begin
            checkValue({rowName[k], " dataAddr"}, rowAddr[k], dataAddr);
            checkValue({rowName[k], " byteEn"}, {28'b0, rowBe[k]}, {28'b0, byteEn});
            checkValue({rowName[k], " writeData"}, rowData[k], writeData);
        end else begin
            checkValue({rowName[k], " byteEn"}, 32'h0, {28'b0, byteEn});
            if (rowKind[k] == KindLoad) begin
                checkValue({rowName[k], " dataAddr"}, rowAddr[k], dataAddr);
            end
        end
    endtask

    initial begin
        wait (built === 1'b1);
        #((rowCount + 20) * ClkPeriod);
        $display(">>> FAIL");
        $fatal(1, "Watchdog expired before the program completed");
    end

    initial begin
        clk      = 1'b0;
        rstN     = 1'b0;
        readData = '0;
        seed     = 20;
        rowCount = 0;
        curPc    = '0;
        built    = 1'b0;
        for (int i = 0; i < 32; i++) begin
            xr[i] = '0;
        end
        for (int i = 0; i < 1024; i++) begin
            imem[i] = iType(i[11:0], 5'd0, 3'd0, 5'd0, OpcodeOpImm); // ADDI x0 filler
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = dmemFill(i[7:0]);
        end

        aluGroup();
        aluGroup();
        storeGroup();
        loadGroup();
        branchGroup();
        jumpGroup();
        upperGroup();
        built = 1'b1;

        repeat (ResetCycles) begin
            @(negedge clk);
            checkValue("reset instrAddr", 32'h0, instrAddr);
            checkValue("reset dataWr", 32'h0, {31'b0, dataWr});
        end

        for (int k = 0; k < rowCount; k++) begin
            @(posedge clk);
            rstN <= 1'b1;
            if (rowKind[k] == KindLoad) begin
                readData <= dmem[rowAddr[k][9:2]];
            end else begin
                readData <= '0;
            end
            @(negedge clk);
            checkRow(k);
        end

        @(posedge clk);
        @(negedge clk);
        checkValue("final instrAddr", rowNext[rowCount - 1], instrAddr);

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: sources.f
src/rvPkg.sv
src/ctrlIf.sv
src/immDecoder.sv
src/controller.sv
src/regFile.sv
src/alu.sv
src/loadStore.sv
src/rvCore.sv
verif/tbRvCore.sv
